// File: dbg_pkg.sv
package dbg_pkg;

	typedef logic [31:0] word_t;
	typedef logic [1:0]  mbox_idx_t;
	typedef logic [3:0]  cmd_t;
	typedef logic [5:0]  reg_sel_t;
	typedef logic [7:0]  mem_idx_t;

	// mailbox word layout
	localparam mbox_idx_t mbox_cmd    = 2'd0;
	localparam mbox_idx_t mbox_addr   = 2'd1;
	localparam mbox_idx_t mbox_data   = 2'd2;
	localparam mbox_idx_t mbox_result = 2'd3;

	localparam cmd_t cmd_halt       = 4'h0;
	localparam cmd_t cmd_run        = 4'h1;
	localparam cmd_t cmd_step       = 4'h2;
	localparam cmd_t cmd_read_reg   = 4'h3;
	localparam cmd_t cmd_write_reg  = 4'h4;
	localparam cmd_t cmd_read_mem   = 4'h5;
	localparam cmd_t cmd_write_mem  = 4'h6;
	localparam cmd_t cmd_get_status = 4'h7;

	localparam int sel_pc_bit = 4; // address bit picking the pc
	localparam int sel_cr_bit = 5; // address bit picking the breakpoint reg
	localparam int gpr_count  = 16;

	localparam int    mem_words = 256;
	localparam int    mem_wait  = 3; // cycles from mem_access to mem_done
	localparam word_t pc_step   = 32'd4;

	typedef logic [$clog2(mem_wait)-1:0] mem_cnt_t;
	localparam mem_cnt_t mem_cnt_init = mem_cnt_t'(mem_wait - 1);

	typedef enum logic [3:0] {
		st_idle,
		st_load_cmd,
		st_load_addr,
		st_load_data,
		st_execute,
		st_wait_stopped,
		st_step,
		st_store_reg,
		st_write_reg,
		st_wait_rmem,
		st_wait_wmem,
		st_compl
	} ctrl_state_t;

endpackage

// File: dbg_mailbox.sv
`timescale 1ns/1ps

module dbg_mailbox
	import dbg_pkg::*;
(
	input  logic      dbg_clk,
	input  logic      clk,
	input  logic      arst_n,
	// host side, dbg_clk
	input  mbox_idx_t addr,
	input  word_t     din,
	output word_t     dout,
	input  logic      wr_en,
	input  logic      req,
	output logic      ack,
	// controller side, clk
	input  mbox_idx_t ctl_addr,
	input  word_t     ctl_din,
	output word_t     ctl_dout,
	input  logic      ctl_wr_en,
	output logic      req_sync,
	input  logic      ack_int
);

	word_t cmd_q;
	word_t addr_q;
	word_t data_q;
	word_t result_q;

	logic [1:0] req_ff;
	logic [1:0] ack_ff;

	function automatic word_t pick(mbox_idx_t idx);
		case (idx)
			mbox_cmd:  return cmd_q;
			mbox_addr: return addr_q;
			mbox_data: return data_q;
			default:   return result_q;
		endcase
	endfunction

	// request words belong to the host, the result word to the controller
	always_ff @(posedge dbg_clk) begin
		if (wr_en) begin
			case (addr)
				mbox_cmd:  cmd_q <= din;
				mbox_addr: addr_q <= din;
				mbox_data: data_q <= din;
				default:   ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ctl_wr_en && ctl_addr == mbox_result)
			result_q <= ctl_din;
	end

	assign dout     = pick(addr);
	assign ctl_dout = pick(ctl_addr);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			req_ff <= '0;
		else
			req_ff <= {req_ff[0], req};
	end

	always_ff @(posedge dbg_clk or negedge arst_n) begin
		if (!arst_n)
			ack_ff <= '0;
		else
			ack_ff <= {ack_ff[0], ack_int};
	end

	assign req_sync = req_ff[1];
	assign ack      = ack_ff[1];

endmodule

// File: dbg_ctrl.sv
`timescale 1ns/1ps

module dbg_ctrl
	import dbg_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	// mailbox
	output mbox_idx_t ctl_addr,
	output word_t     ctl_din,
	input  word_t     ctl_dout,
	output logic      ctl_wr_en,
	input  logic      req_sync,
	output logic      ack_int,
	// execution control
	output logic      run,
	input  logic      stopped,
	input  logic      bkpt_hit,
	// registers
	output reg_sel_t  reg_sel,
	input  word_t     reg_rd_val,
	output word_t     reg_wr_val,
	output logic      reg_wr_en,
	input  word_t     pc,
	output logic      pc_wr_en,
	output logic      cr_wr_en,
	input  word_t     cr_val,
	// memory
	output word_t     mem_addr,
	output word_t     mem_wr_val,
	output logic      mem_wr_en,
	output logic      mem_access,
	input  word_t     mem_rd_val,
	input  logic      mem_done
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	cmd_t  cmd_q;
	word_t addr_q;
	word_t data_q;

	logic do_run;
	logic stopped_on_bkpt;
	logic ack_q;

	assign run        = do_run;
	assign ack_int    = ack_q;
	assign reg_sel    = addr_q[5:0];
	assign reg_wr_val = data_q;
	assign mem_addr   = addr_q;
	assign mem_wr_val = data_q;
	assign mem_wr_en  = (cmd_q == cmd_write_mem) &&
		(state == st_execute || state == st_wait_wmem);

	always_comb begin
		next_state = state;
		ctl_addr   = mbox_cmd;
		ctl_din    = '0;
		ctl_wr_en  = 1'b0;
		reg_wr_en  = 1'b0;
		pc_wr_en   = 1'b0;
		cr_wr_en   = 1'b0;
		mem_access = 1'b0;

		case (state)
			st_idle: begin
				if (req_sync)
					next_state = st_load_cmd;
			end
			st_load_cmd: begin
				ctl_addr   = mbox_cmd;
				next_state = st_load_addr;
			end
			st_load_addr: begin
				ctl_addr   = mbox_addr;
				next_state = st_load_data;
			end
			st_load_data: begin
				ctl_addr   = mbox_data;
				next_state = st_execute;
			end
			st_execute: begin
				case (cmd_q)
					cmd_halt:      next_state = st_wait_stopped;
					cmd_step:      next_state = st_step;
					cmd_read_reg:  next_state = st_store_reg;
					cmd_write_reg: next_state = st_write_reg;
					cmd_read_mem: begin
						mem_access = 1'b1;
						next_state = st_wait_rmem;
					end
					cmd_write_mem: begin
						mem_access = 1'b1;
						next_state = st_wait_wmem;
					end
					cmd_get_status: begin
						ctl_addr   = mbox_result;
						ctl_wr_en  = 1'b1;
						ctl_din    = {30'b0, stopped_on_bkpt, do_run};
						next_state = st_compl;
					end
					default: next_state = st_compl; // run and unknown codes
				endcase
			end
			st_step: next_state = st_wait_stopped; // run high for this cycle only
			st_wait_stopped: begin
				if (stopped) begin
					ctl_addr   = mbox_result;
					ctl_wr_en  = 1'b1;
					ctl_din    = pc;
					next_state = st_compl;
				end
			end
			st_store_reg: begin
				ctl_addr  = mbox_result;
				ctl_wr_en = 1'b1;
				if (addr_q[sel_pc_bit])
					ctl_din = pc;
				else if (addr_q[sel_cr_bit])
					ctl_din = cr_val;
				else
					ctl_din = reg_rd_val;
				next_state = st_compl;
			end
			st_write_reg: begin
				if (addr_q[sel_pc_bit])
					pc_wr_en = 1'b1;
				else if (addr_q[sel_cr_bit])
					cr_wr_en = 1'b1;
				else
					reg_wr_en = 1'b1;
				next_state = st_compl;
			end
			st_wait_rmem: begin
				if (mem_done) begin
					ctl_addr   = mbox_result;
					ctl_wr_en  = 1'b1;
					ctl_din    = mem_rd_val;
					next_state = st_compl;
				end
			end
			st_wait_wmem: begin
				if (mem_done)
					next_state = st_compl;
			end
			st_compl: begin
				if (!req_sync)
					next_state = st_idle; // host has taken the result
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state           <= st_idle;
			do_run          <= 1'b0;
			stopped_on_bkpt <= 1'b0;
			ack_q           <= 1'b0;
		end else begin
			state <= next_state;
			ack_q <= (next_state == st_compl); // registered for the synchronizer

			if (bkpt_hit) begin
				do_run          <= 1'b0;
				stopped_on_bkpt <= 1'b1;
			end

			if (state == st_execute) begin
				case (cmd_q)
					cmd_halt: do_run <= 1'b0;
					cmd_run, cmd_step: begin
						do_run          <= 1'b1;
						stopped_on_bkpt <= 1'b0;
					end
					default: ;
				endcase
			end

			if (state == st_step)
				do_run <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_load_cmd)
			cmd_q <= ctl_dout[3:0];
		if (state == st_load_addr)
			addr_q <= ctl_dout;
		if (state == st_load_data)
			data_q <= ctl_dout;
	end

	a_one_wr_en: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({reg_wr_en, pc_wr_en, cr_wr_en}));

	// the core's done pulse must land inside a memory wait
	a_done_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
		mem_done |-> (state == st_wait_rmem || state == st_wait_wmem));

	a_no_ack_on_write: assert property (@(posedge clk) disable iff (!arst_n)
		ctl_wr_en |-> !ack_int);

endmodule

// File: dbg_core_model.sv
`timescale 1ns/1ps

module dbg_core_model
	import dbg_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     run,
	output logic     stopped,
	output logic     bkpt_hit,
	input  reg_sel_t reg_sel,
	output word_t    reg_rd_val,
	input  word_t    reg_wr_val,
	input  logic     reg_wr_en,
	output word_t    pc,
	input  logic     pc_wr_en,
	input  logic     cr_wr_en,
	output word_t    cr_val,
	input  word_t    mem_addr,
	input  word_t    mem_wr_val,
	input  logic     mem_wr_en,
	input  logic     mem_access,
	output word_t    mem_rd_val,
	output logic     mem_done
);

	word_t regs [gpr_count];
	word_t pc_q;
	word_t cr_q;
	logic  run_q;
	logic  bkpt_stop_q;
	logic  advance;

	word_t    mem [mem_words];
	mem_idx_t idx_q;
	word_t    wdata_q;
	logic     wr_q;
	logic     busy_q;
	mem_cnt_t cnt_q;

	// no compare on the first running cycle, so a resume steps off the breakpoint
	assign bkpt_hit = run && run_q && !bkpt_stop_q && (cr_q != '0) && (pc_q == cr_q);
	assign advance  = run && !bkpt_stop_q && !bkpt_hit;
	assign stopped  = !advance;

	assign pc         = pc_q;
	assign cr_val     = cr_q;
	assign reg_rd_val = regs[reg_sel[3:0]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q        <= '0;
			cr_q        <= '0;
			run_q       <= 1'b0;
			bkpt_stop_q <= 1'b0;
		end else begin
			run_q <= run;
			if (bkpt_hit)
				bkpt_stop_q <= 1'b1;
			else if (!run)
				bkpt_stop_q <= 1'b0; // rearm once run drops
			if (pc_wr_en)
				pc_q <= reg_wr_val;
			else if (advance)
				pc_q <= pc_q + pc_step;
			if (cr_wr_en)
				cr_q <= reg_wr_val;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < gpr_count; i++)
				regs[i] <= '0;
		end else if (reg_wr_en && reg_sel[5:4] == 2'b00) begin
			regs[reg_sel[3:0]] <= reg_wr_val;
		end
	end

	assign mem_done   = busy_q && (cnt_q == '0);
	assign mem_rd_val = mem[idx_q];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
			wr_q   <= 1'b0;
		end else if (mem_access) begin
			busy_q <= 1'b1;
			cnt_q  <= mem_cnt_init;
			wr_q   <= mem_wr_en;
		end else if (busy_q) begin
			if (cnt_q == '0)
				busy_q <= 1'b0;
			else
				cnt_q <= cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_access) begin
			idx_q   <= mem_addr[9:2]; // word index
			wdata_q <= mem_wr_val;
		end
		if (mem_done && wr_q)
			mem[idx_q] <= wdata_q;
	end

	a_access_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		mem_access |-> !busy_q);

endmodule

// File: dbg_top.sv
`timescale 1ns/1ps

module dbg_top
	import dbg_pkg::*;
(
	input  logic      clk,
	input  logic      dbg_clk,
	input  logic      arst_n,
	input  mbox_idx_t addr,
	input  word_t     din,
	output word_t     dout,
	input  logic      wr_en,
	input  logic      req,
	output logic      ack
);

	mbox_idx_t ctl_addr;
	word_t     ctl_din, ctl_dout;
	logic      ctl_wr_en, req_sync, ack_int;
	logic      run, stopped, bkpt_hit;
	reg_sel_t  reg_sel;
	word_t     reg_rd_val, reg_wr_val, pc, cr_val;
	logic      reg_wr_en, pc_wr_en, cr_wr_en;
	word_t     mem_addr, mem_wr_val, mem_rd_val;
	logic      mem_wr_en, mem_access, mem_done;

	dbg_mailbox mailbox_i (
		.dbg_clk, .clk, .arst_n,
		.addr, .din, .dout, .wr_en, .req, .ack,
		.ctl_addr, .ctl_din, .ctl_dout, .ctl_wr_en, .req_sync, .ack_int
	);

	dbg_ctrl ctrl_i (
		.clk, .arst_n,
		.ctl_addr, .ctl_din, .ctl_dout, .ctl_wr_en, .req_sync, .ack_int,
		.run, .stopped, .bkpt_hit,
		.reg_sel, .reg_rd_val, .reg_wr_val, .reg_wr_en, .pc, .pc_wr_en, .cr_wr_en, .cr_val,
		.mem_addr, .mem_wr_val, .mem_wr_en, .mem_access, .mem_rd_val, .mem_done
	);

	dbg_core_model core_i (
		.clk, .arst_n, .run, .stopped, .bkpt_hit,
		.reg_sel, .reg_rd_val, .reg_wr_val, .reg_wr_en, .pc, .pc_wr_en, .cr_wr_en, .cr_val,
		.mem_addr, .mem_wr_val, .mem_wr_en, .mem_access, .mem_rd_val, .mem_done
	);

endmodule

// File: tb_dbg_top.sv
`timescale 1ns/1ps

module tb_dbg_top
	import dbg_pkg::*;
();

	localparam int    cmd_budget = 120; // upper bound on host commands
	localparam int    poll_limit = 20;
	localparam word_t pc_sel     = 32'd1 << sel_pc_bit;
	localparam word_t cr_sel     = 32'd1 << sel_cr_bit;

	logic      clk;
	logic      dbg_clk;
	logic      arst_n;
	mbox_idx_t addr;
	word_t     din;
	word_t     dout;
	logic      wr_en;
	logic      req;
	logic      ack;

	word_t ref_gpr [gpr_count];
	word_t ref_mem [mem_words];
	word_t ref_cr;
	word_t ref_pc;
	logic  ref_run;
	logic  ref_bkpt;

	string chk_name_q [$];
	word_t chk_exp_q [$];
	word_t chk_act_q [$];
	bit    chk_status_q [$];
	int    errors;
	int    checks;

	dbg_top dut_i (.clk, .dbg_clk, .arst_n, .addr, .din, .dout, .wr_en, .req, .ack);

	initial begin
		clk = 1'b0;
		#0.5; // keeps clk edges off the dbg_clk edges
		forever #2 clk = ~clk;
	end

	initial begin
		dbg_clk = 1'b0;
		forever #3 dbg_clk = ~dbg_clk;
	end

	initial begin
		repeat (cmd_budget * 200) @(posedge clk);
		$display("timeout: DUT did not finish the command sequence in time");
		$display(">>> FAIL");
		$finish;
	end

	// expected result word for one command, updates the model state
	function automatic word_t ref_result(cmd_t cmd, word_t a, word_t d);
		word_t res;
		res = '0;
		case (cmd)
			cmd_halt: begin
				ref_run = 1'b0;
				res     = ref_pc;
			end
			cmd_run: begin
				ref_run  = 1'b1;
				ref_bkpt = 1'b0;
			end
			cmd_step: begin
				ref_pc   = ref_pc + pc_step;
				ref_run  = 1'b0;
				ref_bkpt = 1'b0;
				res      = ref_pc;
			end
			cmd_read_reg: res = a[sel_pc_bit] ? ref_pc : a[sel_cr_bit] ? ref_cr : ref_gpr[a[3:0]];
			cmd_write_reg: begin
				if (a[sel_pc_bit])
					ref_pc = d;
				else if (a[sel_cr_bit])
					ref_cr = d;
				else
					ref_gpr[a[3:0]] = d;
			end
			cmd_read_mem:   res = ref_mem[a[9:2]];
			cmd_write_mem:  ref_mem[a[9:2]] = d;
			cmd_get_status: res = {30'b0, ref_bkpt, ref_run};
			default: ;
		endcase
		return res;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h (bkpt %b run %b), actual %h (bkpt %b run %b)",
				name, exp, exp[1], exp[0], act, act[1], act[0]);
		end
	endtask

	task automatic queue_check(input string name, input word_t exp, input word_t act,
		input bit is_status);
		chk_name_q.push_back(name);
		chk_exp_q.push_back(exp);
		chk_act_q.push_back(act);
		chk_status_q.push_back(is_status);
	endtask

	// one full four-phase transaction from the host side
	task automatic host_cmd(input cmd_t cmd, input word_t a, input word_t d, output word_t res);
		@(negedge dbg_clk);
		addr  = mbox_cmd;
		din   = {28'b0, cmd};
		wr_en = 1'b1;
		@(negedge dbg_clk);
		addr = mbox_addr;
		din  = a;
		@(negedge dbg_clk);
		addr = mbox_data;
		din  = d;
		@(negedge dbg_clk);
		wr_en = 1'b0;
		addr  = mbox_result;
		req   = 1'b1;
		while (!ack)
			@(negedge dbg_clk);
		res = dout;
		req = 1'b0;
		while (ack)
			@(negedge dbg_clk);
	endtask

	task automatic issue(input string name, input cmd_t cmd, input word_t a, input word_t d,
		output word_t got);
		word_t exp;
		host_cmd(cmd, a, d, got);
		exp = ref_result(cmd, a, d);
		case (cmd)
			cmd_halt, cmd_step, cmd_read_reg, cmd_read_mem: queue_check(name, exp, got, 1'b0);
			cmd_get_status: queue_check(name, exp, got, 1'b1);
			default: ; // no result word
		endcase
	endtask

	initial begin
		string name;
		word_t exp;
		word_t act;
		bit    is_status;
		forever begin
			@(posedge dbg_clk);
			while (chk_act_q.size() > 0) begin
				name      = chk_name_q.pop_front();
				exp       = chk_exp_q.pop_front();
				act       = chk_act_q.pop_front();
				is_status = chk_status_q.pop_front();
				if (is_status)
					check_status(name, exp, act);
				else
					check_word(name, exp, act);
			end
		end
	end

	initial begin
		word_t got;
		int    idx [20];
		int    order [20];
		int    j;
		int    tmp;
		int    polls;
		void'($urandom(46));
		arst_n = 1'b0;
		addr   = mbox_cmd;
		din    = '0;
		wr_en  = 1'b0;
		req    = 1'b0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < gpr_count; i++)
			ref_gpr[i] = '0;
		ref_cr   = '0;
		ref_pc   = '0;
		ref_run  = 1'b0;
		ref_bkpt = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge dbg_clk);
		arst_n = 1'b1;

		for (int i = 0; i < gpr_count; i++)
			issue($sformatf("write gpr%0d", i), cmd_write_reg, word_t'(i), $urandom, got);
		issue("write cr", cmd_write_reg, cr_sel, $urandom, got);
		for (int i = 0; i < gpr_count; i++)
			issue($sformatf("read gpr%0d", i), cmd_read_reg, word_t'(i), '0, got);
		issue("read cr", cmd_read_reg, cr_sel, '0, got);

		for (int i = 0; i < 20; i++) begin
			idx[i]   = $urandom_range(mem_words - 1, 0);
			order[i] = i;
			issue($sformatf("write mem %0d", idx[i]), cmd_write_mem, word_t'(idx[i]) << 2,
				$urandom, got);
		end
		for (int i = 19; i > 0; i--) begin
			j        = $urandom_range(i, 0);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 20; i++)
			issue($sformatf("read mem %0d", idx[order[i]]), cmd_read_mem,
				word_t'(idx[order[i]]) << 2, '0, got);

		issue("halt from reset", cmd_halt, '0, '0, got);
		issue("write pc", cmd_write_reg, pc_sel, $urandom & 32'h0000_fffc, got);
		issue("read pc", cmd_read_reg, pc_sel, '0, got);
		for (int i = 0; i < 3; i++)
			issue($sformatf("step %0d", i), cmd_step, '0, '0, got);

		issue("clear breakpoint", cmd_write_reg, cr_sel, '0, got);
		issue("run", cmd_run, '0, '0, got);
		issue("status running", cmd_get_status, '0, '0, got);
		host_cmd(cmd_halt, '0, '0, got); // free-running pc, only alignment is known
		void'(ref_result(cmd_halt, '0, '0));
		if (got[1:0] != 2'b00) begin
			errors++;
			$display("error: pc %h returned by halt is not word aligned", got);
		end
		ref_pc = got;
		issue("pc after halt", cmd_read_reg, pc_sel, '0, got);
		issue("status halted", cmd_get_status, '0, '0, got);

		issue("pc to 0x100", cmd_write_reg, pc_sel, 32'h100, got);
		issue("breakpoint 0x140", cmd_write_reg, cr_sel, 32'h140, got);
		issue("run to breakpoint", cmd_run, '0, '0, got);
		polls = 0;
		got   = '0;
		while (!got[1] && polls < poll_limit) begin
			host_cmd(cmd_get_status, '0, '0, got);
			polls++;
		end
		if (!got[1]) begin
			errors++;
			$display("error: breakpoint flag still clear after %0d status polls", polls);
		end
		ref_run  = 1'b0; // core parks on the breakpoint address
		ref_bkpt = 1'b1;
		ref_pc   = ref_cr;
		queue_check("status at breakpoint", ref_result(cmd_get_status, '0, '0), got, 1'b1);
		issue("pc at breakpoint", cmd_read_reg, pc_sel, '0, got);

		issue("step off breakpoint", cmd_step, '0, '0, got);
		issue("status after step", cmd_get_status, '0, '0, got);

		repeat (2) @(negedge dbg_clk);
		$display("done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: sim.f
dbg_pkg.sv
dbg_mailbox.sv
dbg_ctrl.sv
dbg_core_model.sv
dbg_top.sv
tb_dbg_top.sv

// File: Makefile
TOP = tb_dbg_top
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
